/* Makefile */
# Verilator build, run, lint and clean for the matching stage

VERILATOR ?= verilator
TOP ?= match_stage_tb
RTL_TOP ?= match_stage
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Run failed"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Isrc src/match_pkg.sv src/pair_queue.sv \
		src/commit_tracker.sv src/issue_control.sv src/match_stage.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
+incdir+src
src/match_pkg.sv
src/pair_queue.sv
src/commit_tracker.sv
src/issue_control.sv
src/match_stage.sv
verification/match_stage_properties.sv
verification/match_stage_tb.sv

/* src/commit_tracker.sv */
// Issued versus committed instruction counts used to release commit-wait instructions
`timescale 1ns/1ps
`include "match_params.svh"

module commit_tracker (
	input logic iCLOCK,
	input logic inRESET,
	input logic clear,
	input logic issued_0,
	input logic issued_1,
	input logic [`MATCH_COMMIT_OFS_W-1:0] commit_offset,
	output logic all_committed
);

	localparam int CNT_W = `MATCH_CNT_W;

	logic [CNT_W-1:0] issued_cnt;
	logic [CNT_W-1:0] committed_cnt;

	// Both counts wrap, only their equality matters
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			issued_cnt <= '0;
			committed_cnt <= '0;
		end else if (clear) begin
			issued_cnt <= '0;
			committed_cnt <= '0;
		end else begin
			issued_cnt <= issued_cnt + CNT_W'(issued_0) + CNT_W'(issued_1);
			// Commits keep arriving under back-pressure
			committed_cnt <= committed_cnt + CNT_W'(commit_offset);
		end
	end

	assign all_committed = (issued_cnt == committed_cnt);

endmodule

/* src/issue_control.sv */
// Commit-wait FSM that turns the loop buffer head into two issue lanes and buffer pops
`timescale 1ns/1ps

module issue_control
	import match_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic free_default,
	input queue_entry_t head,
	input logic empty,
	input logic next_lock,
	input logic all_committed,
	output logic pop,
	output logic issued_0,
	output logic issued_1,
	output issue_pair_t next
);

	issue_state_t state;
	issue_state_t state_next;
	logic live;
	logic s0_valid;
	logic s0_wait;
	logic s0_ready;
	logic s1_valid;
	logic s1_wait;
	logic s1_ready;
	logic [1:0] lane_valid;
	logic sel_slot1;

	// Head decode
	assign s0_valid = head.slot[0].inst.valid;
	assign s0_wait = s0_valid && head.slot[0].inst.commit_wait;
	assign s0_ready = s0_valid && !head.slot[0].inst.commit_wait;
	assign s1_valid = head.slot[1].inst.valid;
	assign s1_wait = s1_valid && head.slot[1].inst.commit_wait;
	assign s1_ready = s1_valid && !head.slot[1].inst.commit_wait;

	// Nothing moves without a head and an open downstream
	assign live = !empty && !next_lock;

	always_comb begin
		lane_valid = 2'b00;
		pop = 1'b0;
		state_next = state;
		if (live) begin
			case (state)
				ISSUE_NORMAL: begin
					lane_valid[0] = s0_ready;
					lane_valid[1] = s0_ready && s1_ready;
					pop = s0_ready && !s1_wait;
					if (s0_wait) begin
						state_next = ISSUE_WAIT_SLOT0;
					end else if (s1_wait) begin
						state_next = ISSUE_WAIT_SLOT1;
					end
				end
				ISSUE_WAIT_SLOT0: begin
					if (all_committed) begin
						lane_valid[0] = s0_valid;
						lane_valid[1] = s1_ready;
						pop = !s1_wait;
						state_next = s1_wait ? ISSUE_WAIT_SLOT1 : ISSUE_NORMAL;
					end
				end
				ISSUE_WAIT_SLOT1: begin
					// Slot 0 already left, slot 1 goes alone on lane 0
					if (all_committed) begin
						lane_valid[0] = s1_valid;
						pop = 1'b1;
						state_next = ISSUE_NORMAL;
					end
				end
				default: begin
					state_next = ISSUE_NORMAL;
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ISSUE_NORMAL;
		end else if (free_default) begin
			state <= ISSUE_NORMAL;
		end else begin
			state <= state_next;
		end
	end

	assign sel_slot1 = (state == ISSUE_WAIT_SLOT1);

	// Lane assembly, lane 1 is always slot 1
	always_comb begin
		next.lane[0].valid = lane_valid[0];
		next.lane[1].valid = lane_valid[1];
		next.lane[1].payload = head.slot[1].inst.payload;
		if (sel_slot1) begin
			next.lane[0].payload = head.slot[1].inst.payload;
			next.pc = head.slot[1].pc;
		end else begin
			next.lane[0].payload = head.slot[0].inst.payload;
			next.pc = head.slot[0].pc;
		end
	end

	assign issued_0 = lane_valid[0];
	assign issued_1 = lane_valid[1];

endmodule

/* src/match_params.svh */
// Width, depth and threshold macros for the matching stage, included by the package and the RTL
`ifndef MATCH_PARAMS_SVH
`define MATCH_PARAMS_SVH

// Instruction word and field widths
`define MATCH_WORD_W 32
`define MATCH_REG_W 5
`define MATCH_CMD_W 5
`define MATCH_CC_W 4

// Loop buffer geometry, counted in pairs
`define MATCH_QUEUE_DEPTH 16
`define MATCH_QUEUE_PTR_W 4
// Fetch is warned once this many pairs are held
`define MATCH_LIMIT_LEVEL 8

// Issued/committed bookkeeping
`define MATCH_CNT_W 8
`define MATCH_COMMIT_OFS_W 3

// Byte distance between the two instructions of a pair
`define MATCH_PC_STEP 4

`endif

/* src/match_pkg.sv */
// Instruction, pair, lane and issue-state types shared by the matching stage and its testbench
`include "match_params.svh"

package match_pkg;

	// Register view of the second source word
	typedef struct packed {
		logic [`MATCH_WORD_W-`MATCH_REG_W-1:0] pad;
		logic [`MATCH_REG_W-1:0] num;
	} src1_reg_t;

	// Source 1 is an immediate or a register number, chosen by source1_imm
	typedef union packed {
		logic [`MATCH_WORD_W-1:0] imm;
		src1_reg_t src_reg;
	} src1_u;

	// One-hot-ish execution unit selects
	typedef struct packed {
		logic sys_adder;
		logic sys_ldst;
		logic logic_op;
		logic shift;
		logic adder;
		logic mul;
		logic sdiv;
		logic udiv;
		logic ldst;
		logic branch;
	} ex_unit_t;

	typedef struct packed {
		logic [`MATCH_REG_W-1:0] destination;
		logic destination_sysreg;
		logic dest_rename;
		logic writeback;
		logic flags_writeback;
		logic [`MATCH_CMD_W-1:0] cmd;
		logic [`MATCH_CC_W-1:0] cc_afe;
		logic [`MATCH_REG_W-1:0] source0;
		src1_u source1;
		logic source0_flags;
		logic source1_imm;
		logic source0_active;
		logic source1_active;
		logic source0_sysreg;
		logic source1_sysreg;
		logic source0_sysreg_rename;
		logic source1_sysreg_rename;
		ex_unit_t ex_unit;
	} inst_payload_t;

	// Upstream view, one PC shared by the pair
	typedef struct packed {
		logic valid;
		logic commit_wait;
		inst_payload_t payload;
	} fetch_slot_t;

	typedef struct packed {
		fetch_slot_t [1:0] slot;
		logic [`MATCH_WORD_W-1:0] pc;
	} fetch_pair_t;

	// Stored view, each slot keeps its own PC
	typedef struct packed {
		fetch_slot_t inst;
		logic [`MATCH_WORD_W-1:0] pc;
	} queue_slot_t;

	typedef struct packed {
		queue_slot_t [1:0] slot;
	} queue_entry_t;

	// Downstream view
	typedef struct packed {
		logic valid;
		inst_payload_t payload;
	} issue_lane_t;

	typedef struct packed {
		issue_lane_t [1:0] lane;
		logic [`MATCH_WORD_W-1:0] pc;
	} issue_pair_t;

	typedef enum logic [1:0] {
		ISSUE_NORMAL,
		ISSUE_WAIT_SLOT0,
		ISSUE_WAIT_SLOT1
	} issue_state_t;

endpackage

/* src/match_stage.sv */
// Dual-issue matching stage between rename and the schedulers, top of the design
`timescale 1ns/1ps
`include "match_params.svh"

module match_stage
	import match_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic free_default,
	input logic free_restart,
	input logic [`MATCH_COMMIT_OFS_W-1:0] commit_offset,
	input fetch_pair_t prev,
	output logic prev_lock,
	output logic loop_buffer_limit,
	output issue_pair_t next,
	input logic next_lock
);

	queue_entry_t head;
	logic empty;
	logic pop;
	logic issued_0;
	logic issued_1;
	logic all_committed;

	// Loop buffer, full doubles as the upstream lock
	pair_queue pair_queue_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(free_restart),
		.prev(prev),
		.pop(pop),
		.head(head),
		.empty(empty),
		.full(prev_lock),
		.limit(loop_buffer_limit)
	);

	commit_tracker commit_tracker_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.clear(free_restart),
		.issued_0(issued_0),
		.issued_1(issued_1),
		.commit_offset(commit_offset),
		.all_committed(all_committed)
	);

	issue_control issue_control_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.free_default(free_default),
		.head(head),
		.empty(empty),
		.next_lock(next_lock),
		.all_committed(all_committed),
		.pop(pop),
		.issued_0(issued_0),
		.issued_1(issued_1),
		.next(next)
	);

endmodule

/* src/pair_queue.sv */
// Show-ahead loop buffer that stores incoming instruction pairs with per-slot PCs until issue
`timescale 1ns/1ps
`include "match_params.svh"

module pair_queue
	import match_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input fetch_pair_t prev,
	input logic pop,
	output queue_entry_t head,
	output logic empty,
	output logic full,
	output logic limit
);

	localparam int PTR_W = `MATCH_QUEUE_PTR_W;
	localparam int CNT_W = `MATCH_QUEUE_PTR_W + 1;
	localparam logic [CNT_W-1:0] DEPTH = CNT_W'(`MATCH_QUEUE_DEPTH);
	localparam logic [CNT_W-1:0] LIMIT_LEVEL = CNT_W'(`MATCH_LIMIT_LEVEL);
	localparam logic [`MATCH_WORD_W-1:0] PC_STEP = `MATCH_WORD_W'(`MATCH_PC_STEP);

	queue_entry_t mem [`MATCH_QUEUE_DEPTH];
	queue_entry_t wr_entry;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic wr_en;
	logic rd_en;

	// Split the shared PC, slot 1 sits one instruction later
	always_comb begin
		wr_entry.slot[0].inst = prev.slot[0];
		wr_entry.slot[0].pc = prev.pc;
		wr_entry.slot[1].inst = prev.slot[1];
		wr_entry.slot[1].pc = prev.pc + PC_STEP;
	end

	assign wr_en = (prev.slot[0].valid || prev.slot[1].valid) && !full;
	assign rd_en = pop && !empty;

	always_ff @(posedge iCLOCK) begin
		if (wr_en && !flush) begin
			mem[wr_ptr] <= wr_entry;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous write and pop leaves the count alone
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head is visible as soon as it is written
	assign head = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == DEPTH);
	assign limit = (count >= LIMIT_LEVEL);

endmodule

/* verification/match_stage_properties.sv */
// Concurrent checks on the matching stage lock and valid rules, bound to the top level
`timescale 1ns/1ps

module match_stage_properties
	import match_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic next_lock,
	input logic prev_lock,
	input logic loop_buffer_limit,
	input issue_pair_t next
);

	// Lane 1 never runs ahead of lane 0
	lane1_needs_lane0: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next.lane[1].valid |-> next.lane[0].valid)
		else $error("lane 1 valid without lane 0");

	no_valid_under_lock: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next_lock |-> !(next.lane[0].valid || next.lane[1].valid))
		else $error("lane valid while next_lock is high");

	// A full buffer is always above the limit level
	full_implies_limit: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		prev_lock |-> loop_buffer_limit)
		else $error("prev_lock high without loop_buffer_limit");

	quiet_after_reset: assert property (@(posedge iCLOCK)
		$rose(inRESET) |-> !(next.lane[0].valid || next.lane[1].valid))
		else $error("lane valid right after reset release");

endmodule

/* verification/match_stage_tb.sv */
// Directed testbench for the matching stage, run as the simulation top with the bound checks
`timescale 1ns/1ps
`include "match_params.svh"

module match_stage_tb
	import match_pkg::*;
;

	localparam int TEST_CYCLES = 30 + 50 + 40 + 90 + 50;
	localparam int CYCLE_LIMIT = TEST_CYCLES + 100;
	localparam int CNT_W = `MATCH_CNT_W;

	logic iCLOCK = 1'b0;
	logic inRESET;
	logic free_default;
	logic free_restart;
	logic [`MATCH_COMMIT_OFS_W-1:0] commit_offset;
	fetch_pair_t prev;
	logic prev_lock;
	logic loop_buffer_limit;
	issue_pair_t next;
	logic next_lock;

	logic [31:0] seed = 32'd61;
	int mismatches = 0;
	int other_errors = 0;
	int cycles = 0;
	// Model of expected lanes in program order, plus the two counts
	issue_lane_t exp_lane [$];
	logic [`MATCH_WORD_W-1:0] exp_pc [$];
	logic exp_on_lane1 [$];
	logic [`MATCH_CNT_W-1:0] m_issued = '0;
	logic [`MATCH_CNT_W-1:0] m_committed = '0;

	match_stage match_stage_i (.*);

	bind match_stage match_stage_properties match_stage_properties_i (.*);

	always #4 iCLOCK = ~iCLOCK;

	always @(posedge iCLOCK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic inst_payload_t rand_payload(input logic imm);
		inst_payload_t p;
		logic [95:0] bits;
		logic [31:0] r;
		bits = {lcg_next(), lcg_next(), lcg_next()};
		p = bits[$bits(inst_payload_t)-1:0];
		r = lcg_next();
		p.source1_imm = imm;
		if (imm) begin
			p.source1.imm = r;
		end else begin
			p.source1.src_reg.pad = '0;
			p.source1.src_reg.num = r[`MATCH_REG_W-1:0];
		end
		return p;
	endfunction

	task automatic check_lane(input issue_lane_t act, input issue_lane_t exp, input string what);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s lane %h, expected %h", $time, what, act, exp);
		end
	endtask

	task automatic check_pc(input logic [`MATCH_WORD_W-1:0] act,
			input logic [`MATCH_WORD_W-1:0] exp);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: lane 0 pc %h, expected %h", $time, act, exp);
		end
	endtask

	task automatic check_flag(input logic act, input logic exp, input string what);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, act, exp);
		end
	endtask

	// Outputs settle between edges, so the monitor works on the falling edge
	always @(negedge iCLOCK) begin
		if (inRESET) begin
			for (int l = 0; l < 2; l++) begin
				if (next.lane[l].valid) begin
					if (exp_lane.size() == 0) begin
						other_errors++;
						$display("Unexpected issue on lane %0d at %0t with nothing pending",
							l, $time);
					end else begin
						check_lane(next.lane[l], exp_lane.pop_front(), "issued");
						check_flag(l == 1, exp_on_lane1.pop_front(), "issue on lane 1");
						if (l == 0) check_pc(next.pc, exp_pc[0]);
						void'(exp_pc.pop_front());
					end
				end
			end
			if (free_restart) begin
				m_issued = '0;
				m_committed = '0;
			end else begin
				m_issued = m_issued + CNT_W'(next.lane[0].valid) + CNT_W'(next.lane[1].valid);
				m_committed = m_committed + CNT_W'(commit_offset);
			end
		end
	end

	task automatic send_pair(input logic v0, input logic w0, input logic v1, input logic w1,
			input logic imm);
		fetch_pair_t p;
		logic [31:0] r;
		r = lcg_next();
		p.pc = {r[31:2], 2'b00};
		p.slot[0] = '{valid: v0, commit_wait: w0, payload: rand_payload(imm)};
		p.slot[1] = '{valid: v1, commit_wait: w1, payload: rand_payload(!imm)};
		@(posedge iCLOCK);
		prev <= p;
		if (v0) begin
			exp_lane.push_back('{valid: 1'b1, payload: p.slot[0].payload});
			exp_pc.push_back(p.pc);
			exp_on_lane1.push_back(1'b0);
		end
		if (v1) begin
			exp_lane.push_back('{valid: 1'b1, payload: p.slot[1].payload});
			exp_pc.push_back(p.pc + `MATCH_PC_STEP);
			// Slot 1 shares the cycle with slot 0 unless it waits itself
			exp_on_lane1.push_back(v0 && !w1);
		end
		@(posedge iCLOCK);
		prev <= '0;
	endtask

	task automatic drain();
		while (exp_lane.size() != 0) @(negedge iCLOCK);
	endtask

	// Feed commit offsets until the model counts meet
	task automatic commit_all();
		logic [`MATCH_CNT_W-1:0] diff;
		while (m_issued != m_committed) begin
			diff = m_issued - m_committed;
			@(posedge iCLOCK);
			commit_offset <= (diff > 7) ? 3'd7 : diff[2:0];
			@(posedge iCLOCK);
			commit_offset <= '0;
		end
	endtask

	task automatic expect_idle(input int n);
		repeat (n) begin
			@(negedge iCLOCK);
			check_flag(next.lane[0].valid, 1'b0, "lane 0 valid while waiting");
		end
	endtask

	task automatic pair_flow_test();
		send_pair(1, 0, 1, 0, 1);
		send_pair(1, 0, 1, 0, 0);
		send_pair(1, 0, 0, 0, 1);
		drain();
	endtask

	task automatic wait_slot0_test();
		send_pair(1, 1, 1, 0, 1);
		expect_idle(4);
		commit_all();
		drain();
	endtask

	task automatic wait_slot1_test();
		send_pair(1, 0, 1, 1, 0);
		while (exp_lane.size() > 1) @(negedge iCLOCK);
		expect_idle(3);
		commit_all();
		drain();
	endtask

	task automatic backpressure_test();
		@(posedge iCLOCK);
		next_lock <= 1'b1;
		for (int i = 0; i < `MATCH_QUEUE_DEPTH; i++) begin
			send_pair(1, 0, 1, 0, i[0]);
			@(negedge iCLOCK);
			check_flag(loop_buffer_limit, (i + 1) >= `MATCH_LIMIT_LEVEL, "loop_buffer_limit");
			check_flag(prev_lock, (i + 1) == `MATCH_QUEUE_DEPTH, "prev_lock");
		end
		@(posedge iCLOCK);
		next_lock <= 1'b0;
		drain();
		commit_all();
	endtask

	task automatic restart_default_test();
		send_pair(1, 0, 1, 0, 1);
		drain();
		// Slot 1 waits behind uncommitted work and holds the FSM in its slot-1 wait
		send_pair(1, 0, 1, 1, 0);
		while (exp_lane.size() > 1) @(negedge iCLOCK);
		expect_idle(3);
		@(posedge iCLOCK);
		free_restart <= 1'b1;
		free_default <= 1'b1;
		exp_lane.delete();
		exp_pc.delete();
		exp_on_lane1.delete();
		@(posedge iCLOCK);
		free_restart <= 1'b0;
		free_default <= 1'b0;
		expect_idle(4);
		// Cleared counts let a waiting slot 0 go at once
		send_pair(1, 1, 1, 0, 1);
		drain();
	endtask

	initial begin
		inRESET = 1'b0;
		free_default = 1'b0;
		free_restart = 1'b0;
		commit_offset = '0;
		prev = '0;
		next_lock = 1'b0;
		repeat (5) @(posedge iCLOCK);
		inRESET <= 1'b1;
		pair_flow_test();
		wait_slot0_test();
		wait_slot1_test();
		backpressure_test();
		restart_default_test();
		repeat (3) @(posedge iCLOCK);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
		if (mismatches + other_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
